// File: all.f
+incdir+rtl
rtl/mrd_pkg.sv
rtl/mrd_mem_bank.sv
rtl/mrd_ctrl_fsm.sv
rtl/mrd_dft_top.sv
dv/mrd_tb.sv

// File: dv/mrd_tb.sv
/*
 * Testbench for the ping-pong DFT data-movement core. Applies a table of frame
 * tests, predicts each output frame with a two-stage transpose model and checks
 * data and framing of every output beat.
 */

`include "mrd_cfg.svh"

module mrd_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_tests     = 5;
	localparam int sop_timeout   = 400;
	localparam int drain_timeout = 400;

	typedef enum logic
	{
		DATA_RAMP,
		DATA_RAND
	} data_kind_e;

	typedef enum logic
	{
		GAP_NONE,
		GAP_RAND
	} gap_mode_e;

	// one test: frames to send (and to expect back), data and pacing
	typedef struct packed
	{
		logic [3:0] frames;
		data_kind_e kind;
		gap_mode_e  gaps;
	} test_row_t;

	logic               clk;
	logic               rst_n;
	mrd_pkg::mrd_word_t sink_in;
	mrd_pkg::mrd_word_t source_out;

	test_row_t tests [num_tests];
	string     test_names [num_tests];

	integer             seed;
	logic [`MRD_DW-1:0] tx_frame [`MRD_N];
	logic [`MRD_DW-1:0] model_buf [`MRD_N];
	logic [`MRD_DW-1:0] exp_q [$];
	logic [`MRD_DW-1:0] exp_word;

	int err_count;
	int err_base;
	int tests_failed;
	int sent_count;
	int sop_count;
	int frames_done;
	int beat_idx;
	bit in_frame;
	bit timed_out;

	mrd_dft_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.sink_in    (sink_in),
		.source_out (source_out)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// --------------------
	// reporting
	// --------------------
	task automatic report_error(input string msg);
		$display("** Error @ %0d ns: %s", $time, msg);
		err_count++;
	endtask

	// --------------------
	// reference model
	// --------------------
	// output a*m+b takes input b*f+a
	task automatic stage_transpose(input int f);
		logic [`MRD_DW-1:0] tmp [`MRD_N];
		int m;
		int a;
		int b;
		int i;
		m = `MRD_N / f;
		for (a = 0; a < f; a++)
			for (b = 0; b < m; b++)
				tmp[a * m + b] = model_buf[b * f + a];
		for (i = 0; i < `MRD_N; i++)
			model_buf[i] = tmp[i];
	endtask

	// both stages, then queue the expected output frame
	task automatic predict_frame();
		int i;
		for (i = 0; i < `MRD_N; i++)
			model_buf[i] = tx_frame[i];
		stage_transpose(`MRD_FACTOR0);
		stage_transpose(`MRD_FACTOR1);
		for (i = 0; i < `MRD_N; i++)
			exp_q.push_back(model_buf[i]);
	endtask

	// --------------------
	// stimulus
	// --------------------
	task automatic fill_frame(input data_kind_e kind);
		int i;
		for (i = 0; i < `MRD_N; i++)
		begin
			if (kind == DATA_RAMP)
				tx_frame[i] = `MRD_DW'(i);
			else
				tx_frame[i] = `MRD_DW'($random(seed));
		end
	endtask

	// beats go out on the falling edge, idle beats are all zero
	task automatic send_frame(input gap_mode_e gaps);
		int i;
		int k;
		int gap;
		sent_count++;
		for (i = 0; i < `MRD_N; i++)
		begin
			if (gaps == GAP_RAND && i != 0)
			begin
				gap = $random(seed) & 3;
				for (k = 0; k < gap; k++)
				begin
					@(negedge clk);
					sink_in = '0;
				end
			end
			@(negedge clk);
			sink_in = '{data: tx_frame[i], valid: 1'b1, sop: (i == 0),
				eop: (i == `MRD_N - 1)};
		end
		@(negedge clk);
		sink_in = '0;
	endtask

	// no strobes on the output for a number of cycles
	task automatic check_quiet(input int cycles);
		int i;
		for (i = 0; i < cycles; i++)
		begin
			@(negedge clk);
			assert (!source_out.valid && !source_out.sop && !source_out.eop)
			else
				report_error("output strobe seen while the core should be idle");
		end
	endtask

	// --------------------
	// waits
	// --------------------
	// the sink rule allows the next sop once this frame has started out
	task automatic wait_output_sop();
		int cycles;
		cycles = 0;
		while (sop_count < sent_count && cycles < sop_timeout)
		begin
			@(posedge clk);
			cycles++;
		end
		if (sop_count < sent_count)
		begin
			$display("timeout: frame %0d produced no output start within %0d cycles",
				sent_count, sop_timeout);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < drain_timeout)
		begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0)
		begin
			$display("timeout: %0d expected output beats never arrived", exp_q.size());
			timed_out = 1'b1;
		end
	endtask

	// --------------------
	// output monitor
	// --------------------
	// sampled mid-cycle, checks framing and data against the model queue
	always @(negedge clk)
	begin
		assert (source_out.valid || (!source_out.sop && !source_out.eop))
		else
			report_error("sop or eop without valid on the output");
		if (source_out.valid)
		begin
			assert (!(in_frame && source_out.sop))
			else
				report_error($sformatf("sop inside an output frame at beat %0d", beat_idx));
			if (source_out.sop)
			begin
				in_frame = 1'b1;
				beat_idx = 0;
				sop_count++;
			end
			assert (in_frame)
			else
				report_error("valid output beat outside any frame");
			assert (exp_q.size() != 0)
			else
				report_error("output beat while no frame was expected");
			if (exp_q.size() != 0)
			begin
				exp_word = exp_q.pop_front();
				assert (source_out.data == exp_word)
				else
					report_error($sformatf("data at beat %0d is %h, expected %h",
						beat_idx, source_out.data, exp_word));
			end
			assert (source_out.eop == (beat_idx == `MRD_N - 1))
			else
				report_error($sformatf("eop wrong at beat %0d", beat_idx));
			// frame closes on eop or on the N-th beat, whichever comes first
			if (in_frame && (source_out.eop || beat_idx == `MRD_N - 1))
			begin
				in_frame = 1'b0;
				frames_done++;
			end
			else
				beat_idx++;
		end
		else
		begin
			assert (!in_frame)
			else
				report_error($sformatf("gap in output frame after beat %0d", beat_idx));
			in_frame = 1'b0;
		end
	end

	// --------------------
	// one table row
	// --------------------
	task automatic run_test(input int idx);
		test_row_t row;
		int base_frames;
		int f;
		int errs;
		row = tests[idx];
		base_frames = frames_done;
		if (row.frames == 0)
			check_quiet(20);
		for (f = 0; f < int'(row.frames) && !timed_out; f++)
		begin
			fill_frame(row.kind);
			predict_frame();
			send_frame(row.gaps);
			wait_output_sop();
		end
		if (!timed_out)
			wait_drain();
		assert (frames_done - base_frames == int'(row.frames))
		else
			report_error($sformatf("%0d output frames, expected %0d",
				frames_done - base_frames, row.frames));
		// row 0 also owns anything seen during reset
		errs = err_count - err_base;
		err_base = err_count;
		if (errs != 0 || timed_out)
			tests_failed++;
		$display("test %0d %s: %s, %0d frames out, %0d errors", idx, test_names[idx],
			(errs == 0 && !timed_out) ? "ok" : "FAILED", frames_done - base_frames, errs);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial
	begin
		seed         = 32'h00243153;
		rst_n        = 1'b0;
		sink_in      = '0;
		err_count    = 0;
		err_base     = 0;
		tests_failed = 0;
		sent_count   = 0;
		sop_count    = 0;
		frames_done  = 0;
		beat_idx     = 0;
		in_frame     = 1'b0;
		timed_out    = 1'b0;

		tests[0] = '{frames: 4'd0, kind: DATA_RAMP, gaps: GAP_NONE};
		tests[1] = '{frames: 4'd1, kind: DATA_RAMP, gaps: GAP_NONE};
		tests[2] = '{frames: 4'd2, kind: DATA_RAMP, gaps: GAP_NONE};
		tests[3] = '{frames: 4'd5, kind: DATA_RAND, gaps: GAP_NONE};
		tests[4] = '{frames: 4'd3, kind: DATA_RAND, gaps: GAP_RAND};
		test_names[0] = "reset_quiet";
		test_names[1] = "single_ramp";
		test_names[2] = "framing";
		test_names[3] = "back_to_back";
		test_names[4] = "gapped_sink";

		// 16 cycles of reset, output must stay idle throughout
		check_quiet(16);
		rst_n = 1'b1;

		for (int t = 0; t < num_tests && !timed_out; t++)
			run_test(t);

		$display("summary: %0d tests, %0d failed, %0d check errors",
			num_tests, tests_failed, err_count);
		if (err_count == 0 && tests_failed == 0 && !timed_out)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: rtl/mrd_dft_top.sv
/*
 * Top of the DFT data-movement core. Two ping-pong banks and the frame FSM;
 * the switches steer the input stream, the stage transfer and the output stream.
 */

module mrd_dft_top (
	input  logic                clk,
	input  logic                rst_n,
	input  mrd_pkg::mrd_word_t  sink_in,
	output mrd_pkg::mrd_word_t  source_out
);

	// no valid, no strobes
	localparam mrd_pkg::mrd_word_t idle_word = '0;

	mrd_pkg::mrd_stat_t stat0;
	mrd_pkg::mrd_stat_t stat1;
	mrd_pkg::mrd_ctrl_t ctrl0;
	mrd_pkg::mrd_ctrl_t ctrl1;
	logic               sw_in;
	logic               sw_out;
	logic               sw_1to0;

	mrd_pkg::mrd_word_t sink0;
	mrd_pkg::mrd_word_t sink1;
	mrd_pkg::mrd_word_t xfer_in0;
	mrd_pkg::mrd_word_t xfer_in1;
	mrd_pkg::mrd_word_t xfer_out0;
	mrd_pkg::mrd_word_t xfer_out1;
	mrd_pkg::mrd_word_t source0;
	mrd_pkg::mrd_word_t source1;

	// --------------------
	// routing
	// --------------------
	// input stream to the bank picked by sw_in
	assign sink0 = sw_in ? idle_word : sink_in;
	assign sink1 = sw_in ? sink_in : idle_word;

	// stage transfer, reader into writer
	// sw_1to0 high: bank 1 reads, bank 0 writes
	assign xfer_in0 = sw_1to0 ? xfer_out1 : idle_word;
	assign xfer_in1 = sw_1to0 ? idle_word : xfer_out0;

	// output from the bank holding the finished frame
	assign source_out = sw_out ? source1 : source0;

	// --------------------
	// banks
	// --------------------
	mrd_mem_bank mem0_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl0),
		.sink_in    (sink0),
		.xfer_in    (xfer_in0),
		.stat       (stat0),
		.xfer_out   (xfer_out0),
		.source_out (source0)
	);

	mrd_mem_bank mem1_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl1),
		.sink_in    (sink1),
		.xfer_in    (xfer_in1),
		.stat       (stat1),
		.xfer_out   (xfer_out1),
		.source_out (source1)
	);

	// --------------------
	// control
	// --------------------
	mrd_ctrl_fsm ctrl_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.stat0   (stat0),
		.stat1   (stat1),
		.ctrl0   (ctrl0),
		.ctrl1   (ctrl1),
		.sw_in   (sw_in),
		.sw_out  (sw_out),
		.sw_1to0 (sw_1to0)
	);

endmodule

// File: rtl/mrd_ctrl_fsm.sv
/*
 * Frame control for the two banks. Tracks sink, stage passes and source,
 * counts finished stages and issues per-bank commands and routing switches.
 */

`include "mrd_cfg.svh"

module mrd_ctrl_fsm (
	input  logic                clk,
	input  logic                rst_n,
	input  mrd_pkg::mrd_stat_t  stat0,
	input  mrd_pkg::mrd_stat_t  stat1,
	output mrd_pkg::mrd_ctrl_t  ctrl0,
	output mrd_pkg::mrd_ctrl_t  ctrl1,
	output logic                sw_in,
	output logic                sw_out,
	output logic                sw_1to0
);

	localparam logic [`MRD_SW-1:0] last_stage = `MRD_SW'(`MRD_NUM_STAGES);
	localparam bit odd_stages = ((`MRD_NUM_STAGES % 2) == 1);

	localparam mrd_pkg::mrd_ctrl_t sink_cmd =
		'{state: mrd_pkg::MEM_SINK, current_stage: '0};
	localparam mrd_pkg::mrd_ctrl_t source_cmd =
		'{state: mrd_pkg::MEM_SOURCE, current_stage: '0};

	mrd_pkg::fsm_state_e state;
	logic [`MRD_SW-1:0]  cnt_stage;
	logic                wr0_q;
	logic                wr1_q;
	logic                wr_fall;
	logic                stages_done;
	logic                wr_dir;

	// --------------------
	// stage bookkeeping
	// --------------------
	assign stages_done = (cnt_stage == last_stage);
	// 1 means bank 0 is the writer in this stage
	assign wr_dir      = sw_in ^ cnt_stage[0];
	// end of a stage, seen on the writer only
	assign wr_fall     = sw_1to0 ? (wr0_q & ~stat0.wr_ongoing)
	                             : (wr1_q & ~stat1.wr_ongoing);

	// --------------------
	// frame FSM
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= mrd_pkg::FSM_WAIT;
		else
		begin
			case (state)
				// idle, an older frame may still be sourcing
				mrd_pkg::FSM_WAIT:
				begin
					if (stat0.sink_sop | stat1.sink_sop)
						state <= mrd_pkg::FSM_SINK;
				end
				// filling, wait for sink done and old source gone
				mrd_pkg::FSM_SINK:
				begin
					if (!stat0.sink_ongoing && !stat1.sink_ongoing &&
					    !stat0.source_ongoing && !stat1.source_ongoing)
						state <= mrd_pkg::FSM_CALC;
				end
				mrd_pkg::FSM_CALC:
				begin
					if (stages_done)
						state <= mrd_pkg::FSM_SOURCE;
				end
				// single cycle, source runs on in the bank
				mrd_pkg::FSM_SOURCE:
				begin
					state <= mrd_pkg::FSM_WAIT;
				end
			endcase
		end
	end

	// --------------------
	// stage counter
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cnt_stage <= '0;
			wr0_q     <= 1'b0;
			wr1_q     <= 1'b0;
		end
		else
		begin
			wr0_q <= stat0.wr_ongoing;
			wr1_q <= stat1.wr_ongoing;
			if (state == mrd_pkg::FSM_CALC)
			begin
				if (wr_fall)
					cnt_stage <= cnt_stage + 1'b1;
			end
			else
				cnt_stage <= '0;
		end
	end

	// --------------------
	// bank switches
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sw_in   <= 1'b0;
			sw_out  <= 1'b0;
			sw_1to0 <= 1'b0;
		end
		else
		begin
			case (state)
				mrd_pkg::FSM_CALC:
				begin
					// result ends in the input bank for an even stage count
					sw_out <= odd_stages ? ~sw_in : sw_in;
					// hold direction once all stages are through
					if (!stages_done)
						sw_1to0 <= wr_dir;
				end
				mrd_pkg::FSM_SOURCE:
				begin
					// next frame goes into the bank not sourcing
					sw_in   <= ~sw_out;
					sw_1to0 <= 1'b0;
				end
				default:
				begin
					sw_1to0 <= 1'b0;
				end
			endcase
		end
	end

	// --------------------
	// bank commands
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ctrl0 <= sink_cmd;
			ctrl1 <= sink_cmd;
		end
		else
		begin
			case (state)
				// only the input bank is pulled into SINK
				mrd_pkg::FSM_WAIT, mrd_pkg::FSM_SINK:
				begin
					ctrl0 <= sw_in ? ctrl0 : sink_cmd;
					ctrl1 <= sw_in ? sink_cmd : ctrl1;
				end
				mrd_pkg::FSM_CALC:
				begin
					if (!stages_done)
					begin
						ctrl0 <= '{state: wr_dir ? mrd_pkg::MEM_WR : mrd_pkg::MEM_RD,
							current_stage: cnt_stage};
						ctrl1 <= '{state: wr_dir ? mrd_pkg::MEM_RD : mrd_pkg::MEM_WR,
							current_stage: cnt_stage};
					end
				end
				mrd_pkg::FSM_SOURCE:
				begin
					ctrl0 <= sw_out ? sink_cmd : source_cmd;
					ctrl1 <= sw_out ? source_cmd : sink_cmd;
				end
			endcase
		end
	end

	// a lost or extra wr_ongoing edge would push the count past the end
	a_stage_range: assert property (@(posedge clk) disable iff (!rst_n)
		cnt_stage <= last_stage);

	// commands lag the state by one clock, so check from the second CALC cycle
	// the reading bank must be done with its own write pass
	a_calc_pair: assert property (@(posedge clk) disable iff (!rst_n)
		(state == mrd_pkg::FSM_CALC && $past(state) == mrd_pkg::FSM_CALC) |->
		((ctrl0.state == mrd_pkg::MEM_RD && ctrl1.state == mrd_pkg::MEM_WR &&
		  !stat0.wr_ongoing) ||
		 (ctrl0.state == mrd_pkg::MEM_WR && ctrl1.state == mrd_pkg::MEM_RD &&
		  !stat1.wr_ongoing)));

endmodule

// File: rtl/mrd_mem_bank.sv
/*
 * One ping-pong memory bank. Holds a full frame and runs whichever sequencer
 * its command selects: sink, source, stage read (stride-transposed) or stage write.
 */

`include "mrd_cfg.svh"

module mrd_mem_bank (
	input  logic                clk,
	input  logic                rst_n,
	input  mrd_pkg::mrd_ctrl_t  ctrl,
	input  mrd_pkg::mrd_word_t  sink_in,
	input  mrd_pkg::mrd_word_t  xfer_in,
	output mrd_pkg::mrd_stat_t  stat,
	output mrd_pkg::mrd_word_t  xfer_out,
	output mrd_pkg::mrd_word_t  source_out
);

	localparam logic [`MRD_AW-1:0] last_addr = `MRD_AW'(`MRD_N - 1);

	// frame storage
	logic [`MRD_DW-1:0] ram [`MRD_N];

	// command decode and pass start
	mrd_pkg::mrd_ctrl_t ctrl_q;
	logic               pass_start;
	logic               is_sink;
	logic               is_rd;
	logic               is_wr;
	logic               is_source;

	// sink side
	logic [`MRD_AW-1:0] sink_pos;
	logic [`MRD_AW-1:0] sink_addr;
	logic               sink_wr;
	logic               sink_sop_q;
	logic               sink_ongoing_q;

	// stage write side
	logic [`MRD_AW-1:0] wr_pos;
	logic               xfer_wr;
	logic               wr_ongoing_q;

	// shared write port
	logic               wr_en;
	logic [`MRD_AW-1:0] wr_addr;
	logic [`MRD_DW-1:0] wr_data;

	// read sequencer, shared by RD and SOURCE
	logic               rd_active;
	logic               rd_src;
	logic [`MRD_AW-1:0] rd_pos;
	logic [`MRD_AW-1:0] rd_addr;
	logic [`MRD_AW-1:0] rd_base;
	logic [`MRD_AW-1:0] rd_b;
	logic [`MRD_AW-1:0] rd_step;
	logic [`MRD_AW-1:0] rd_last_b;
	logic [`MRD_AW-1:0] step_sel;
	logic [`MRD_AW-1:0] last_b_sel;

	// read output register
	logic [`MRD_DW-1:0] out_data;
	logic               out_valid;
	logic               out_sop;
	logic               out_eop;
	logic               out_src;

	// --------------------
	// command decode
	// --------------------
	assign is_sink    = (ctrl.state == mrd_pkg::MEM_SINK);
	assign is_rd      = (ctrl.state == mrd_pkg::MEM_RD);
	assign is_wr      = (ctrl.state == mrd_pkg::MEM_WR);
	assign is_source  = (ctrl.state == mrd_pkg::MEM_SOURCE);
	// any change of command or stage kicks off a new pass
	assign pass_start = (ctrl != ctrl_q);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ctrl_q <= '0;
		else
			ctrl_q <= ctrl;
	end

	// --------------------
	// write port
	// --------------------
	assign sink_wr   = is_sink & sink_in.valid;
	// sop always lands at word 0
	assign sink_addr = sink_in.sop ? '0 : sink_pos;
	assign xfer_wr   = is_wr & xfer_in.valid;
	assign wr_en     = sink_wr | xfer_wr;

	always_comb
	begin
		if (xfer_wr)
		begin
			wr_addr = wr_pos;
			wr_data = xfer_in.data;
		end
		else
		begin
			wr_addr = sink_addr;
			wr_data = sink_in.data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_en)
			ram[wr_addr] <= wr_data;
	end

	// --------------------
	// sink sequencer
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sink_pos       <= '0;
			sink_sop_q     <= 1'b0;
			sink_ongoing_q <= 1'b0;
		end
		else
		begin
			sink_sop_q <= sink_wr & sink_in.sop;
			if (sink_wr)
			begin
				sink_pos <= sink_addr + 1'b1;
				// last beat closes the frame, sop opens it
				if (sink_addr == last_addr)
					sink_ongoing_q <= 1'b0;
				else if (sink_in.sop)
					sink_ongoing_q <= 1'b1;
			end
		end
	end

	// --------------------
	// stage write sequencer
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_pos       <= '0;
			wr_ongoing_q <= 1'b0;
		end
		else if (pass_start & is_wr)
			wr_pos <= '0;
		else if (xfer_wr)
		begin
			wr_pos       <= wr_pos + 1'b1;
			// drops with the last write, FSM counts this edge
			wr_ongoing_q <= (wr_pos != last_addr);
		end
	end

	// --------------------
	// read sequencer
	// --------------------
	// stride and inner span per pass, source is plain sequential
	always_comb
	begin
		if (is_source)
		begin
			step_sel   = `MRD_AW'(1);
			last_b_sel = last_addr;
		end
		else if (ctrl.current_stage == '0)
		begin
			step_sel   = `MRD_AW'(`MRD_FACTOR0);
			last_b_sel = `MRD_AW'(`MRD_N / `MRD_FACTOR0 - 1);
		end
		else
		begin
			step_sel   = `MRD_AW'(`MRD_FACTOR1);
			last_b_sel = `MRD_AW'(`MRD_N / `MRD_FACTOR1 - 1);
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_active <= 1'b0;
			rd_src    <= 1'b0;
			rd_pos    <= '0;
			rd_addr   <= '0;
			rd_base   <= '0;
			rd_b      <= '0;
			rd_step   <= '0;
			rd_last_b <= '0;
		end
		else if (pass_start & (is_rd | is_source))
		begin
			rd_active <= 1'b1;
			rd_src    <= is_source;
			rd_pos    <= '0;
			rd_addr   <= '0;
			rd_base   <= '0;
			rd_b      <= '0;
			rd_step   <= step_sel;
			rd_last_b <= last_b_sel;
		end
		else if (rd_active)
		begin
			rd_pos <= rd_pos + 1'b1;
			if (rd_pos == last_addr)
				rd_active <= 1'b0;
			// addr = b*f + a, walk b first then step a
			if (rd_b == rd_last_b)
			begin
				rd_b    <= '0;
				rd_base <= rd_base + 1'b1;
				rd_addr <= rd_base + 1'b1;
			end
			else
			begin
				rd_b    <= rd_b + 1'b1;
				rd_addr <= rd_addr + rd_step;
			end
		end
	end

	// registered read data
	always_ff @(posedge clk)
	begin
		out_data <= ram[rd_addr];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
			out_src   <= 1'b0;
		end
		else
		begin
			out_valid <= rd_active;
			out_sop   <= rd_active & (rd_pos == '0);
			out_eop   <= rd_active & (rd_pos == last_addr);
			out_src   <= rd_src;
		end
	end

	// --------------------
	// outputs
	// --------------------
	// one read stream, steered to source or to the other bank
	assign source_out = '{data: out_data, valid: out_valid & out_src,
		sop: out_sop & out_src, eop: out_eop & out_src};
	assign xfer_out   = '{data: out_data, valid: out_valid & ~out_src,
		sop: out_sop & ~out_src, eop: out_eop & ~out_src};

	assign stat = '{sink_sop: sink_sop_q, sink_ongoing: sink_ongoing_q,
		source_ongoing: out_valid & out_src, wr_ongoing: wr_ongoing_q};

	// a frame longer than MRD_N would run the sink pointer off the end
	a_wr_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_addr < `MRD_AW'(`MRD_N)));

	// FSM must never start a stage pass while a sink is still filling
	a_sink_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(sink_ongoing_q && wr_ongoing_q));

endmodule

// File: rtl/mrd_pkg.sv
/*
 * Shared types for the ping-pong DFT core: bank commands, FSM states and the
 * packed status, command and sample beat structs used between blocks.
 */

`include "mrd_cfg.svh"

package mrd_pkg;

	// --------------------
	// bank command codes
	// --------------------
	typedef enum logic [1:0]
	{
		MEM_SINK   = 2'b00,
		MEM_RD     = 2'b01,
		MEM_WR     = 2'b10,
		MEM_SOURCE = 2'b11
	} mem_state_e;

	// frame FSM
	typedef enum logic [1:0]
	{
		FSM_WAIT   = 2'b00,
		FSM_SINK   = 2'b01,
		FSM_CALC   = 2'b10,
		FSM_SOURCE = 2'b11
	} fsm_state_e;

	// --------------------
	// bundles
	// --------------------
	// bank status back to the FSM, all levels except sink_sop
	typedef struct packed
	{
		logic sink_sop;
		logic sink_ongoing;
		logic source_ongoing;
		logic wr_ongoing;
	} mrd_stat_t;

	// command from the FSM to one bank
	typedef struct packed
	{
		mem_state_e              state;
		logic [`MRD_SW-1:0]      current_stage;
	} mrd_ctrl_t;

	// one sample beat, valid/sop/eop are single-cycle strobes
	typedef struct packed
	{
		logic [`MRD_DW-1:0]      data;
		logic                    valid;
		logic                    sop;
		logic                    eop;
	} mrd_word_t;

endpackage

// File: rtl/mrd_cfg.svh
/*
 * Frame geometry for the mixed-radix DFT data path.
 * Included by the package and by every RTL module that sizes its logic from it.
 */

`ifndef MRD_CFG_SVH
`define MRD_CFG_SVH

// --------------------
// frame and word sizes
// --------------------
`define MRD_N           12
`define MRD_DW          16
`define MRD_AW          4

// --------------------
// stage factoring, product equals MRD_N
// --------------------
`define MRD_NUM_STAGES  2
`define MRD_FACTOR0     4
`define MRD_FACTOR1     3
`define MRD_SW          2

`endif
